//--- all.f
source/read_ig_pkg.sv
source/ar_cmd_if.sv
source/read_cmd_decode.sv
source/os_tracker.sv
source/ar_skid_pipe.sv
source/read_ig_cvt.sv
test/tb_clock_gen.sv
test/read_ig_cvt_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run with Verilator, then search the log for the fail message
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --top-module read_ig_cvt_tb -f all.f -o read_ig_cvt_sim > sim.log 2>&1 \
  && ./obj_dir/read_ig_cvt_sim >> sim.log 2>&1 \
  || echo "TEST FAILED" >> sim.log
grep -q "TEST FAILED" sim.log && { cat sim.log; exit 1; }
grep -q "TEST OK" sim.log || { cat sim.log; exit 1; }
echo "simulation passed"
exit 0

//--- test/read_ig_cvt_tb.sv
// table-driven testbench for the read ingress converter, reference model and scoreboard
module read_ig_cvt_tb;

  localparam int addr_w   = 32;
  localparam int os_cnt_w = 9;
  localparam int pd_w     = addr_w + 11;
  localparam int wait_max = 200;
  // hold rows release the return pulses after this many blocked cycles
  localparam int hold_cycles = 12;

  // one table row, request fields plus stimulus timing
  typedef struct {
    logic [3:0]        id;
    logic [addr_w-1:0] addr;
    logic [2:0]        size;
    logic              swz;
    logic              odd;
    logic              ltran;
    logic              ftran;
    int                stall;
    int                cq_block;
    bit                hold;
    int                limit;
  } row_t;

  logic              nvdla_core_clk;
  logic              nvdla_core_rstn;
  logic              req_valid;
  logic              req_ready;
  logic [pd_w-1:0]   req_pd;
  logic              cq_wr_valid;
  logic              cq_wr_ready;
  logic [3:0]        cq_wr_thread_id;
  logic [6:0]        cq_wr_pd;
  logic              ar_valid;
  logic              ar_ready;
  logic [7:0]        ar_id;
  logic [addr_w-1:0] ar_addr;
  logic [3:0]        ar_len;
  logic [7:0]        rd_os_limit;
  logic              rsp_done;

  row_t rows[$];
  int   sb_q[$];
  int   cur_row;
  int   stall_max;
  int   stall_left;
  bit   rsp_en;
  int   owed;
  int   model_cnt;
  int   model_rsp_d;
  int   n_accept;
  int   n_xfer;
  int   errors;
  bit   saw_block;

  tb_clock_gen i_tb_clock_gen (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn)
  );

  read_ig_cvt #(.addr_w(addr_w), .os_cnt_w(os_cnt_w)) i_read_ig_cvt (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .req_valid       (req_valid),
    .req_ready       (req_ready),
    .req_pd          (req_pd),
    .cq_wr_valid     (cq_wr_valid),
    .cq_wr_ready     (cq_wr_ready),
    .cq_wr_thread_id (cq_wr_thread_id),
    .cq_wr_pd        (cq_wr_pd),
    .ar_valid        (ar_valid),
    .ar_ready        (ar_ready),
    .ar_id           (ar_id),
    .ar_addr         (ar_addr),
    .ar_len          (ar_len),
    .rd_os_limit     (rd_os_limit),
    .rsp_done        (rsp_done)
  );

  // ==========================================================================
  // checks and reference rules
  // ==========================================================================

  task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                             input string what);
    if (got !== exp) begin
      errors++;
      $display("Fail at time %0t: %s, got %0h expected %0h", $time, what, got, exp);
      $display("TEST FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout at time %0t: %s did not happen in time", $time, what);
    $display("TEST FAILED");
    $fatal(1, "wait timed out");
  endtask

  // size[2:1], plus one for a swizzled single transfer with odd size
  function automatic logic [1:0] exp_len(input row_t r);
    logic inc;
    inc = r.ftran & r.ltran & r.swz & r.size[0];
    return r.size[2:1] + {1'b0, inc};
  endfunction

  // len, swizzle, odd, ltran, fdrop, ldrop from low to high
  function automatic logic [6:0] exp_cq(input row_t r);
    logic [2:0] slot;
    logic [2:0] last_slot;
    logic       fdrop;
    logic       ldrop;
    slot      = r.addr[7:5];
    last_slot = slot + r.size;
    fdrop     = r.ftran & slot[0];
    ldrop     = r.ltran & ~last_slot[0];
    return {ldrop, fdrop, r.ltran, r.odd, r.swz, exp_len(r)};
  endfunction

  function automatic logic [pd_w-1:0] pack_req(input row_t r);
    return {r.ftran, r.ltran, r.odd, r.swz, r.size, r.addr, r.id};
  endfunction

  task automatic add_row(input logic [3:0] id, input logic [31:0] addr,
                         input logic [2:0] size, input logic swz, input logic odd,
                         input logic ltran, input logic ftran, input int stall,
                         input int cq_block, input bit hold, input int limit);
    row_t r;
    r.id       = id;
    r.addr     = addr;
    r.size     = size;
    r.swz      = swz;
    r.odd      = odd;
    r.ltran    = ltran;
    r.ftran    = ftran;
    r.stall    = stall;
    r.cq_block = cq_block;
    r.hold     = hold;
    r.limit    = limit;
    rows.push_back(r);
  endtask

  // ==========================================================================
  // background drivers
  // ==========================================================================

  // random ar_ready stalls, length bounded by the current row
  always @(posedge nvdla_core_clk) begin
    if (nvdla_core_rstn) begin
      if (stall_left > 0) begin
        ar_ready <= 1'b0;
        stall_left--;
      end else begin
        ar_ready <= 1'b1;
        if (stall_max > 0 && ($urandom % 3) == 0) begin
          stall_left = ($urandom % stall_max) + 1;
        end
      end
    end
  end

  // one return pulse per owed beat, random spacing
  always @(posedge nvdla_core_clk) begin
    if (nvdla_core_rstn && rsp_en && owed > 0 && ($urandom % 2) == 1) begin
      rsp_done <= 1'b1;
      owed--;
    end else begin
      rsp_done <= 1'b0;
    end
  end

  // ==========================================================================
  // monitor, samples at the falling edge where everything is settled
  // ==========================================================================

  always @(negedge nvdla_core_clk) begin
    int  beats;
    int  inp_cnt;
    bit  acc;
    row_t r;
    if (nvdla_core_rstn) begin
      // address transfers leave in request order
      if (ar_valid && ar_ready) begin
        if (sb_q.size() == 0) begin
          errors++;
          $display("address transfer seen with no request outstanding");
          $display("TEST FAILED");
          $fatal(1, "unexpected transfer");
        end else begin
          r = rows[sb_q.pop_front()];
          check_value(ar_id, {4'h0, r.id}, "ar_id");
          check_value(ar_addr, {r.addr[31:6], 6'h00}, "ar_addr");
          check_value(ar_len, {2'b00, exp_len(r)}, "ar_len");
          n_xfer++;
        end
      end
      // interlock with the context queue
      if (!cq_wr_ready) begin
        check_value(req_ready, 1'b0, "req_ready with cq_wr_ready low");
      end
      // outstanding full rule
      r       = rows[cur_row];
      beats   = int'(exp_len(r)) + 1;
      inp_cnt = model_cnt + (req_valid ? beats : 0) - model_rsp_d;
      if (inp_cnt > int'(rd_os_limit) + 1) begin
        check_value(req_ready, 1'b0, "req_ready while outstanding full");
        check_value(cq_wr_valid, 1'b0, "cq_wr_valid while outstanding full");
      end
      acc = req_valid && req_ready;
      // context write goes with the acceptance
      if (acc) begin
        check_value(cq_wr_valid, 1'b1, "cq_wr_valid at accept");
        check_value(cq_wr_thread_id, r.id, "cq_wr_thread_id");
        check_value(cq_wr_pd, exp_cq(r), "cq_wr_pd");
        sb_q.push_back(cur_row);
        n_accept++;
        owed += beats;
      end
      // count seen by the DUT from the next cycle
      model_cnt   = model_cnt + (acc ? beats : 0) - model_rsp_d;
      model_rsp_d = int'(rsp_done);
    end
  end

  // ==========================================================================
  // main sequence
  // ==========================================================================

  task automatic send_row(input int idx);
    row_t r;
    int   waited;
    bit   done;
    r = rows[idx];
    cur_row     = idx;
    stall_max   <= (r.cq_block > 0) ? 0 : r.stall;
    rsp_en      <= !r.hold;
    req_pd      <= pack_req(r);
    req_valid   <= 1'b1;
    rd_os_limit <= r.limit[7:0];
    cq_wr_ready <= (r.cq_block == 0);
    // context queue blocked, pipe drains and nothing new leaves
    if (r.cq_block > 0) begin
      for (int c = 0; c < r.cq_block; c++) begin
        @(negedge nvdla_core_clk);
        if (c == r.cq_block - 1) begin
          check_value(ar_valid, 1'b0, "ar_valid with cq blocked");
        end
        @(posedge nvdla_core_clk);
      end
      cq_wr_ready <= 1'b1;
      stall_max   <= r.stall;
    end
    waited = 0;
    done   = 0;
    while (!done) begin
      @(negedge nvdla_core_clk);
      if (req_valid && req_ready) begin
        done = 1;
      end else begin
        waited++;
        if (r.hold && waited == hold_cycles) begin
          // still blocked, let the returns free the count
          saw_block = 1;
          rsp_en    <= 1'b1;
        end
        if (waited > wait_max) begin
          report_timeout("request acceptance");
        end
      end
    end
    @(posedge nvdla_core_clk);
  endtask

  initial begin
    int waited;
    void'($urandom(32'h5133f365));
    req_valid   = 1'b0;
    req_pd      = '0;
    cq_wr_ready = 1'b1;
    ar_ready    = 1'b0;
    rd_os_limit = 8'd255;
    rsp_done    = 1'b0;
    cur_row     = 0;
    stall_max   <= 0;
    stall_left  = 0;
    rsp_en      <= 1'b1;
    owed        = 0;
    model_cnt   = 0;
    model_rsp_d = 0;
    n_accept    = 0;
    n_xfer      = 0;
    errors      = 0;
    saw_block   = 0;

    // id addr size swz odd lt ft stall cqblk hold limit
    add_row(4'h1, 32'h1000_0020, 3'd1, 0, 0, 1, 1, 0, 0, 0, 255);
    add_row(4'h2, 32'h1000_0040, 3'd3, 1, 0, 1, 1, 0, 0, 0, 255);
    add_row(4'h3, 32'h2000_00a7, 3'd2, 0, 1, 0, 1, 0, 0, 0, 255);
    add_row(4'h4, 32'h3000_0000, 3'd7, 0, 0, 1, 1, 2, 0, 0, 255);
    add_row(4'h5, 32'h3000_00c0, 3'd1, 0, 1, 1, 0, 3, 0, 0, 255);
    add_row(4'h6, 32'h4000_0160, 3'd4, 1, 0, 1, 1, 4, 0, 0, 255);
    add_row(4'h7, 32'h4000_0e3f, 3'd5, 1, 1, 1, 1, 4, 0, 0, 255);
    add_row(4'h8, 32'h5000_0080, 3'd0, 0, 0, 1, 1, 3, 0, 0, 255);
    // context queue stall
    add_row(4'h9, 32'h5000_01a0, 3'd3, 0, 0, 1, 0, 2, 10, 0, 255);
    add_row(4'ha, 32'h6000_0020, 3'd6, 1, 1, 0, 0, 4, 0, 0, 255);
    // outstanding limit, returns held off
    add_row(4'hb, 32'h7000_0000, 3'd6, 0, 0, 1, 1, 0, 0, 1, 3);
    add_row(4'hc, 32'h7000_0100, 3'd1, 0, 0, 1, 1, 0, 0, 1, 3);
    add_row(4'hd, 32'h7000_0240, 3'd2, 1, 0, 0, 1, 1, 0, 1, 3);
    add_row(4'he, 32'h7000_0360, 3'd5, 1, 1, 1, 1, 2, 0, 1, 3);
    add_row(4'hf, 32'h8000_0ff0, 3'd3, 1, 0, 1, 1, 3, 0, 0, 3);

    // reset state
    waited = 0;
    while (!nvdla_core_rstn) begin
      @(negedge nvdla_core_clk);
      waited++;
      if (waited > 40) begin
        report_timeout("reset release");
      end
    end
    check_value(ar_valid, 1'b0, "ar_valid after reset");
    @(posedge nvdla_core_clk);

    foreach (rows[i]) begin
      send_row(i);
    end
    req_valid <= 1'b0;
    stall_max <= 0;
    rsp_en    <= 1'b1;

    // drain the address path
    waited = 0;
    while (sb_q.size() > 0) begin
      @(negedge nvdla_core_clk);
      waited++;
      if (waited > wait_max) begin
        report_timeout("address path drain");
      end
    end

    check_value(n_accept, rows.size(), "accepted request count");
    check_value(n_xfer, rows.size(), "address transfer count");
    check_value(saw_block, 1'b1, "outstanding limit reached");

    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- test/tb_clock_gen.sv
// testbench clock and active-low reset generator
module tb_clock_gen #(
  parameter int half_period = 4,
  parameter int rst_cycles  = 16
) (
  output logic nvdla_core_clk,
  output logic nvdla_core_rstn
);

  initial begin
    nvdla_core_clk  = 1'b0;
    nvdla_core_rstn = 1'b0;
  end

  // period 8
  always #(half_period) nvdla_core_clk = ~nvdla_core_clk;

  // release reset after the fixed cycle count
  initial begin
    repeat (rst_cycles) @(posedge nvdla_core_clk);
    nvdla_core_rstn <= 1'b1;
  end

endmodule

//--- source/read_ig_cvt.sv
// top level of the read ingress converter, block wiring and AXI zero extension
module read_ig_cvt #(
  parameter int addr_w   = 32,
  parameter int os_cnt_w = 9
) (
  input  logic                                       nvdla_core_clk,
  input  logic                                       nvdla_core_rstn,
  // request in
  input  logic                                       req_valid,
  output logic                                       req_ready,
  input  logic [addr_w+read_ig_pkg::req_w_extra-1:0] req_pd,
  // context queue write
  output logic                                       cq_wr_valid,
  input  logic                                       cq_wr_ready,
  output logic [read_ig_pkg::req_id_w-1:0]           cq_wr_thread_id,
  output logic [read_ig_pkg::cq_entry_w-1:0]         cq_wr_pd,
  // AXI read address
  output logic                                       ar_valid,
  input  logic                                       ar_ready,
  output logic [read_ig_pkg::ar_id_w-1:0]            ar_id,
  output logic [addr_w-1:0]                          ar_addr,
  output logic [read_ig_pkg::ar_len_w-1:0]           ar_len,
  // outstanding control
  input  logic [read_ig_pkg::os_limit_w-1:0]         rd_os_limit,
  input  logic                                       rsp_done
);
  import read_ig_pkg::*;

  logic                   os_full;
  logic [burst_len_w-1:0] req_len;
  logic                   ar_accept;
  logic [req_id_w-1:0]    ar_pd_id;
  logic [burst_len_w-1:0] ar_pd_len;

  // decoder to skid pipe
  ar_cmd_if #(.addr_w(addr_w)) ar_cmd ();

  // =========================================================================
  // decode and interlock
  // =========================================================================

  read_cmd_decode #(.addr_w(addr_w)) i_read_cmd_decode (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .req_valid       (req_valid),
    .req_ready       (req_ready),
    .req_pd          (req_pd),
    .cq_wr_valid     (cq_wr_valid),
    .cq_wr_ready     (cq_wr_ready),
    .cq_wr_thread_id (cq_wr_thread_id),
    .cq_wr_pd        (cq_wr_pd),
    .os_full         (os_full),
    .req_len         (req_len),
    .ar_cmd          (ar_cmd.src)
  );

  // counts beats at command issue
  assign ar_accept = ar_cmd.vld & ar_cmd.rdy;

  os_tracker #(.os_cnt_w(os_cnt_w)) i_os_tracker (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .req_valid       (req_valid),
    .req_len         (req_len),
    .ar_accept       (ar_accept),
    .rsp_done        (rsp_done),
    .rd_os_limit     (rd_os_limit),
    .os_full         (os_full)
  );

  // =========================================================================
  // output pipe
  // =========================================================================

  ar_skid_pipe #(.addr_w(addr_w)) i_ar_skid_pipe (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .ar_cmd          (ar_cmd.dst),
    .ar_valid        (ar_valid),
    .ar_ready        (ar_ready),
    .ar_pd_id        (ar_pd_id),
    .ar_pd_addr      (ar_addr),
    .ar_pd_len       (ar_pd_len)
  );

  // AXI id and len wider than internal fields
  assign ar_id  = {{(ar_id_w-req_id_w){1'b0}}, ar_pd_id};
  assign ar_len = {{(ar_len_w-burst_len_w){1'b0}}, ar_pd_len};

endmodule

//--- source/ar_skid_pipe.sv
// registered-ready skid register plus bubble-collapsing pipe register, address path
module ar_skid_pipe #(
  parameter int addr_w = 32
) (
  input  logic                                nvdla_core_clk,
  input  logic                                nvdla_core_rstn,
  // command in
  ar_cmd_if.dst                               ar_cmd,
  // AXI read address out
  output logic                                ar_valid,
  input  logic                                ar_ready,
  output logic [read_ig_pkg::req_id_w-1:0]    ar_pd_id,
  output logic [addr_w-1:0]                   ar_pd_addr,
  output logic [read_ig_pkg::burst_len_w-1:0] ar_pd_len
);
  import read_ig_pkg::*;

  // id, addr, len packed
  localparam int pd_w = req_id_w + addr_w + burst_len_w;

  logic [pd_w-1:0] in_pd;

  // skid stage
  logic            rdy_q;
  logic            skid_catch;
  logic            skid_ready;
  logic            skid_valid;
  logic [pd_w-1:0] skid_data;
  logic            skid_pipe_valid;
  logic [pd_w-1:0] skid_pipe_data;

  // pipe stage
  logic            pipe_valid;
  logic            pipe_ready_bc;
  logic [pd_w-1:0] pipe_data;

  assign in_pd = {ar_cmd.id, ar_cmd.addr, ar_cmd.len};

  // =========================================================================
  // skid register
  // =========================================================================

  // upstream still sees ready while the pipe has stalled
  always_comb begin
    skid_catch = ar_cmd.vld && rdy_q && !pipe_ready_bc;
    // hold ready low until the caught entry moves on
    skid_ready = skid_valid ? pipe_ready_bc : !skid_catch;
  end

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      skid_valid <= 1'b0;
      rdy_q      <= 1'b1;
    end else begin
      skid_valid <= skid_valid ? !pipe_ready_bc : skid_catch;
      rdy_q      <= skid_ready;
    end
  end

  // payload only
  always_ff @(posedge nvdla_core_clk) begin
    if (skid_catch) begin
      skid_data <= in_pd;
    end
  end

  assign ar_cmd.rdy = rdy_q;

  // bypass while ready was high, else drain the skid entry
  always_comb begin
    skid_pipe_valid = rdy_q ? ar_cmd.vld : skid_valid;
    skid_pipe_data  = rdy_q ? in_pd : skid_data;
  end

  // =========================================================================
  // pipe register
  // =========================================================================

  // empty slot accepts even when downstream stalls
  assign pipe_ready_bc = ar_ready || !pipe_valid;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      pipe_valid <= 1'b0;
    end else begin
      pipe_valid <= pipe_ready_bc ? skid_pipe_valid : 1'b1;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (pipe_ready_bc && skid_pipe_valid) begin
      pipe_data <= skid_pipe_data;
    end
  end

  // output
  assign ar_valid = pipe_valid;
  assign {ar_pd_id, ar_pd_addr, ar_pd_len} = pipe_data;

endmodule

//--- source/os_tracker.sv
// outstanding beat counter, delayed return pulse, full flag against the limit
module os_tracker #(
  parameter int os_cnt_w = 9
) (
  input  logic                                nvdla_core_clk,
  input  logic                                nvdla_core_rstn,
  // pending request and its length
  input  logic                                req_valid,
  input  logic [read_ig_pkg::burst_len_w-1:0] req_len,
  // address command transfer
  input  logic                                ar_accept,
  // one pulse per returned beat
  input  logic                                rsp_done,
  input  logic [read_ig_pkg::os_limit_w-1:0]  rd_os_limit,
  output logic                                os_full
);
  import read_ig_pkg::*;

  logic                  rsp_done_d;
  logic [os_cnt_w-1:0]   os_cnt;
  logic [os_cnt_w-1:0]   os_cnt_nxt;
  // beats of the request on the input
  logic [os_add_w-1:0]   req_beats;
  // beats actually issued this cycle
  logic [os_add_w-1:0]   acc_beats;
  // one extra bit so the compare sees overflow
  logic [os_cnt_w:0]     os_inp_nxt;
  logic [os_cnt_w:0]     limit_ext;

  // =========================================================================
  // return pulse
  // =========================================================================

  // egress pulse registered once, count drops a cycle later
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      rsp_done_d <= 1'b0;
    end else begin
      rsp_done_d <= rsp_done;
    end
  end

  // =========================================================================
  // full flag
  // =========================================================================

  // len is beats minus one
  assign req_beats = req_valid ? os_add_w'(req_len) + os_add_w'(1) : '0;
  assign acc_beats = ar_accept ? os_add_w'(req_len) + os_add_w'(1) : '0;

  // count as it would be if this request went out
  assign os_inp_nxt = {1'b0, os_cnt} + (os_cnt_w+1)'(req_beats)
                    - (os_cnt_w+1)'(rsp_done_d);
  assign limit_ext  = (os_cnt_w+1)'(rd_os_limit) + (os_cnt_w+1)'(1);

  // combinational, feeds the interlock in the same cycle
  assign os_full = os_inp_nxt > limit_ext;

  // =========================================================================
  // counter
  // =========================================================================

  assign os_cnt_nxt = os_cnt + os_cnt_w'(acc_beats) - os_cnt_w'(rsp_done_d);

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      os_cnt <= '0;
    end else if (ar_accept || rsp_done_d) begin
      os_cnt <= os_cnt_nxt;
    end
  end

endmodule

//--- source/read_cmd_decode.sv
// request unpack, address align, burst length, context entry, three-way interlock
module read_cmd_decode #(
  parameter int addr_w = 32
) (
  input  logic                                      nvdla_core_clk,
  input  logic                                      nvdla_core_rstn,
  // request in
  input  logic                                      req_valid,
  output logic                                      req_ready,
  input  logic [addr_w+read_ig_pkg::req_w_extra-1:0] req_pd,
  // context queue write
  output logic                                      cq_wr_valid,
  input  logic                                      cq_wr_ready,
  output logic [read_ig_pkg::req_id_w-1:0]          cq_wr_thread_id,
  output logic [read_ig_pkg::cq_entry_w-1:0]        cq_wr_pd,
  // outstanding tracker
  input  logic                                      os_full,
  output logic [read_ig_pkg::burst_len_w-1:0]       req_len,
  // command to the skid pipe
  ar_cmd_if.src                                     ar_cmd
);
  import read_ig_pkg::*;

  // unpacked request fields
  logic [req_id_w-1:0]    cmd_id;
  logic [addr_w-1:0]      cmd_addr;
  logic [req_size_w-1:0]  cmd_size;
  logic                   cmd_swizzle;
  logic                   cmd_odd;
  logic                   cmd_ltran;
  logic                   cmd_ftran;

  // derived
  logic [slot_w-1:0]      stt_slot;
  logic [slot_w-1:0]      end_slot;
  logic                   len_inc;
  logic [burst_len_w-1:0] cmd_len;
  logic [addr_w-1:0]      cmd_addr_aligned;
  logic                   fdrop;
  logic                   ldrop;

  // =========================================================================
  // unpack
  // =========================================================================

  assign cmd_id      = req_pd[req_id_lsb +: req_id_w];
  assign cmd_addr    = req_pd[req_addr_lsb +: addr_w];
  assign cmd_size    = req_pd[addr_w+req_size_off +: req_size_w];
  assign cmd_swizzle = req_pd[addr_w+req_swizzle_off];
  assign cmd_odd     = req_pd[addr_w+req_odd_off];
  assign cmd_ltran   = req_pd[addr_w+req_ltran_off];
  assign cmd_ftran   = req_pd[addr_w+req_ftran_off];

  // =========================================================================
  // address and length
  // =========================================================================

  // drop low 6 bits, 64B beat boundary
  assign cmd_addr_aligned = {cmd_addr[addr_w-1:align_bits], {align_bits{1'b0}}};

  // swizzled single transfer with odd size needs one extra beat
  assign len_inc = cmd_ftran & cmd_ltran & cmd_size[0] & cmd_swizzle;
  // size counts 32B slots minus one, halved for 64B beats
  assign cmd_len = cmd_size[burst_len_w:1] + {{(burst_len_w-1){1'b0}}, len_inc};
  assign req_len = cmd_len;

  // =========================================================================
  // context entry
  // =========================================================================

  // start slot inside the 256B block
  assign stt_slot = cmd_addr[line_offset_lsb +: slot_w];
  // end slot, carry out never happens within one block
  assign end_slot = stt_slot + cmd_size;

  // first beat starts on the upper half, lower 32B discarded
  assign fdrop = cmd_ftran & stt_slot[0];
  // last beat ends on the lower half, upper 32B discarded
  assign ldrop = cmd_ltran & ~end_slot[0];

  assign cq_wr_pd[cq_len_lsb +: burst_len_w] = cmd_len;
  assign cq_wr_pd[cq_swizzle_bit]             = cmd_swizzle;
  assign cq_wr_pd[cq_odd_bit]                 = cmd_odd;
  assign cq_wr_pd[cq_ltran_bit]               = cmd_ltran;
  assign cq_wr_pd[cq_fdrop_bit]               = fdrop;
  assign cq_wr_pd[cq_ldrop_bit]               = ldrop;
  assign cq_wr_thread_id                      = cmd_id;

  // =========================================================================
  // interlock
  // =========================================================================

  // each side waits on the other two, so both fire in the same cycle
  assign cq_wr_valid = req_valid & ar_cmd.rdy & ~os_full;
  assign ar_cmd.vld  = req_valid & cq_wr_ready & ~os_full;
  assign req_ready   = ar_cmd.rdy & cq_wr_ready & ~os_full;

  // command payload
  assign ar_cmd.id   = cmd_id;
  assign ar_cmd.addr = cmd_addr_aligned;
  assign ar_cmd.len  = cmd_len;

endmodule

//--- source/ar_cmd_if.sv
// interface for the decoded read-address command, decoder to skid pipe
interface ar_cmd_if #(
  parameter int addr_w = 32
);
  import read_ig_pkg::*;

  // handshake, transfer when both high
  logic                   vld;
  // registered inside the skid pipe
  logic                   rdy;

  // command payload
  logic [req_id_w-1:0]    id;
  // already 64B aligned
  logic [addr_w-1:0]      addr;
  // beats minus one
  logic [burst_len_w-1:0] len;

  // decoder side
  modport src (
    output vld, id, addr, len,
    input  rdy
  );

  // skid pipe side
  modport dst (
    input  vld, id, addr, len,
    output rdy
  );

endinterface

//--- source/read_ig_pkg.sv
// request and context-entry field layout, AXI widths, outstanding-count widths
package read_ig_pkg;

  // =========================================================================
  // request word
  // =========================================================================

  // thread id and size field widths
  localparam int req_id_w   = 4;
  localparam int req_size_w = 3;
  // bits besides the address: id 4, size 3, swizzle, odd, ltran, ftran
  localparam int req_w_extra = 11;

  // fixed low fields
  localparam int req_id_lsb   = 0;
  localparam int req_addr_lsb = 4;
  // fields above the address, offsets relative to addr_w
  localparam int req_size_off    = 4;
  localparam int req_swizzle_off = 7;
  localparam int req_odd_off     = 8;
  localparam int req_ltran_off   = 9;
  localparam int req_ftran_off   = 10;

  // =========================================================================
  // AXI read address side
  // =========================================================================

  // external id and len, zero-extended at the top
  localparam int ar_id_w  = 8;
  localparam int ar_len_w = 4;
  // internal burst length, up to 4 beats
  localparam int burst_len_w = 2;

  // 32B slot index inside a 256B block, addr[7:5]
  localparam int line_offset_lsb = 5;
  localparam int slot_w          = 3;
  // AXI beats are 64B, low bits cleared
  localparam int align_bits = 6;

  // =========================================================================
  // context queue entry
  // =========================================================================

  localparam int cq_entry_w = 7;
  // len in [1:0], then single-bit flags
  localparam int cq_len_lsb     = 0;
  localparam int cq_swizzle_bit = 2;
  localparam int cq_odd_bit     = 3;
  localparam int cq_ltran_bit   = 4;
  localparam int cq_fdrop_bit   = 5;
  localparam int cq_ldrop_bit   = 6;

  // =========================================================================
  // outstanding tracking
  // =========================================================================

  // programmable limit register width
  localparam int os_limit_w = 8;
  // beats per command, len+1 fits in 3 bits
  localparam int os_add_w = burst_len_w + 1;

endpackage
